// ==== test/lsu_golden.txt ====
# alloc tag dv data | agu tag addr | cdb tag data | commit tag | drain
# load tag addr expected ; tags in decimal, addresses and data in hex
alloc 1 1 11111111
alloc 2 0 00000000
agu 1 00000010
agu 2 00000014
cdb 2 22222222
commit 2
commit 1
drain
load 20 00000010 11111111
load 21 00000014 22222222
# fill all eight entries, two stores to 0x20
alloc 3 1 aaaa0003
alloc 4 0 00000000
alloc 5 1 cccc0005
alloc 6 1 00000006
alloc 7 1 00000007
alloc 8 1 00000008
alloc 9 1 00000009
alloc 10 1 0000000a
agu 10 00000038
agu 5 00000020
agu 4 00000024
agu 3 00000020
agu 6 00000028
agu 7 0000002c
agu 8 00000030
agu 9 00000034
cdb 4 bbbb0004
commit 5
commit 3
commit 9
commit 4
commit 10
commit 6
commit 8
commit 7
drain
load 22 00000020 cccc0005
load 23 00000024 bbbb0004
load 24 00000038 0000000a
# load ahead of the commit sees the old word
alloc 11 1 77777777
agu 11 00000010
commit 11
load 25 00000010 11111111
drain
load 26 00000010 77777777

// ==== src.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/store_queue.sv
logic/load_unit.sv
logic/mem_arbiter.sv
logic/data_mem.sv
logic/lsu_top.sv
test/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f src.f --top-module lsu_tb -o Vlsu_tb
./obj_dir/Vlsu_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
grep -q "Simulation PASSED" sim.log

// ==== test/lsu_tb.sv ====
// load/store slice testbench
`include "lsu_cfg.svh"

module lsu_tb;

	typedef logic [`LSU_XLEN-1:0] word_t;
	typedef logic [8*16-1:0] cmd_t;

	// cycles any single wait may take
	localparam int WAIT_LIMIT = 500;

	// pending event kinds
	localparam int EV_AGU = 0;
	localparam int EV_CDB = 1;
	localparam int EV_COMMIT = 2;

	logic clk;
	logic reset;
	logic stq_alloc;
	logic [`LSU_TAG_W-1:0] alloc_tag;
	word_t alloc_data;
	logic alloc_data_valid;
	logic agu_valid;
	logic [`LSU_TAG_W-1:0] agu_tag;
	word_t agu_addr;
	logic cdb_valid;
	logic [`LSU_TAG_W-1:0] cdb_tag;
	word_t cdb_data;
	logic commit_valid;
	logic [`LSU_TAG_W-1:0] commit_tag;
	logic load_valid;
	logic [`LSU_TAG_W-1:0] load_tag;
	word_t load_addr;
	logic sq_credit;
	logic ld_credit;
	logic load_result_valid;
	logic [`LSU_TAG_W-1:0] load_result_tag;
	word_t load_result_data;

	// shadow credits, spent by dispatch and returned by pulses
	int sq_spent = 0;
	int sq_returned = 0;
	int ld_spent = 0;
	int ld_returned = 0;
	// marks at the previous drain
	int sq_spent_mark = 0;
	int sq_returned_mark = 0;

	// last load result seen
	int ld_results = 0;
	logic [`LSU_TAG_W-1:0] seen_tag;
	word_t seen_data;

	int fail_count = 0;
	integer seed;

	// agu, cdb and commit events held back until the next drain
	int ev_kind [$];
	logic [`LSU_TAG_W-1:0] ev_tag [$];
	word_t ev_val [$];

	lsu_top dut0 (
		.clk(clk), .reset(reset),
		.stq_alloc(stq_alloc), .alloc_tag(alloc_tag),
		.alloc_data(alloc_data), .alloc_data_valid(alloc_data_valid),
		.agu_valid(agu_valid), .agu_tag(agu_tag), .agu_addr(agu_addr),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.commit_valid(commit_valid), .commit_tag(commit_tag),
		.load_valid(load_valid), .load_tag(load_tag), .load_addr(load_addr),
		.sq_credit(sq_credit), .ld_credit(ld_credit),
		.load_result_valid(load_result_valid), .load_result_tag(load_result_tag),
		.load_result_data(load_result_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// outputs move on the rising edge, so sample them on the falling one
	always @(negedge clk) begin
		if (sq_credit) begin
			sq_returned = sq_returned + 1;
		end
		if (ld_credit) begin
			ld_returned = ld_returned + 1;
		end
		if (load_result_valid) begin
			seen_tag = load_result_tag;
			seen_data = load_result_data;
			ld_results = ld_results + 1;
		end
	end

	// inputs change 1 unit after the edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input word_t got, input word_t expected, input string what);
		if (got !== expected) begin
			fail_count++;
			$display("mismatch at %0t: %s, got %h expected %h", $time, what, got, expected);
			$display("Simulation FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic report_stall(input string what);
		$display("timeout at %0t: %s", $time, what);
		$display("Simulation FAILED");
		$fatal(1, "stopped on timeout");
	endtask

	task automatic alloc_store(input logic [`LSU_TAG_W-1:0] tag, input logic dv, input word_t data);
		int waited;
		waited = 0;
		// block until a queue slot is free
		while (`LSU_STQ_SIZE + sq_returned - sq_spent == 0) begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_stall("no store credit came back for allocation");
			end
		end
		stq_alloc = 1'b1;
		alloc_tag = tag;
		alloc_data = data;
		alloc_data_valid = dv;
		sq_spent++;
		next_cycle();
		stq_alloc = 1'b0;
		alloc_data_valid = 1'b0;
	endtask

	task automatic issue_event(input int kind, input logic [`LSU_TAG_W-1:0] tag, input word_t val);
		case (kind)
			EV_AGU: begin
				agu_valid = 1'b1;
				agu_tag = tag;
				agu_addr = val;
			end
			EV_CDB: begin
				cdb_valid = 1'b1;
				cdb_tag = tag;
				cdb_data = val;
			end
			default: begin
				commit_valid = 1'b1;
				commit_tag = tag;
			end
		endcase
		next_cycle();
		agu_valid = 1'b0;
		cdb_valid = 1'b0;
		commit_valid = 1'b0;
	endtask

	// fisher-yates over the pending events
	task automatic shuffle_events();
		int j;
		int kind_tmp;
		logic [`LSU_TAG_W-1:0] tag_tmp;
		word_t val_tmp;
		for (int i = ev_kind.size() - 1; i > 0; i--) begin
			j = $unsigned($random(seed)) % (i + 1);
			kind_tmp = ev_kind[i];
			tag_tmp = ev_tag[i];
			val_tmp = ev_val[i];
			ev_kind[i] = ev_kind[j];
			ev_tag[i] = ev_tag[j];
			ev_val[i] = ev_val[j];
			ev_kind[j] = kind_tmp;
			ev_tag[j] = tag_tmp;
			ev_val[j] = val_tmp;
		end
	endtask

	// pending address and data go out now, commits stay queued for the drain
	task automatic issue_addr_and_data();
		int kind_keep [$];
		logic [`LSU_TAG_W-1:0] tag_keep [$];
		word_t val_keep [$];
		int kind;
		logic [`LSU_TAG_W-1:0] tag;
		word_t val;
		shuffle_events();
		while (ev_kind.size() > 0) begin
			kind = ev_kind.pop_front();
			tag = ev_tag.pop_front();
			val = ev_val.pop_front();
			if (kind == EV_COMMIT) begin
				kind_keep.push_back(kind);
				tag_keep.push_back(tag);
				val_keep.push_back(val);
			end else begin
				issue_event(kind, tag, val);
			end
		end
		ev_kind = kind_keep;
		ev_tag = tag_keep;
		ev_val = val_keep;
	endtask

	task automatic drain_stores();
		int waited;
		shuffle_events();
		while (ev_kind.size() > 0) begin
			issue_event(ev_kind.pop_front(), ev_tag.pop_front(), ev_val.pop_front());
		end
		// every allocated store must retire and hand its credit back
		waited = 0;
		while (sq_returned != sq_spent) begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_stall("store queue did not drain");
			end
		end
		// a few idle cycles to catch stray pulses
		repeat (3) next_cycle();
		check_value(word_t'(`LSU_STQ_SIZE + sq_returned - sq_spent), word_t'(`LSU_STQ_SIZE),
				"store credits after drain");
		check_value(word_t'(sq_returned - sq_returned_mark), word_t'(sq_spent - sq_spent_mark),
				"sq_credit pulses for stores since last drain");
		sq_spent_mark = sq_spent;
		sq_returned_mark = sq_returned;
	endtask

	task automatic issue_load(input logic [`LSU_TAG_W-1:0] tag, input word_t addr,
			input word_t expected);
		int waited;
		int results_mark;
		// an uncommitted store ahead of the load is complete except for its commit
		issue_addr_and_data();
		waited = 0;
		while (1 + ld_returned - ld_spent == 0) begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_stall("no load credit came back");
			end
		end
		results_mark = ld_results;
		load_valid = 1'b1;
		load_tag = tag;
		load_addr = addr;
		ld_spent++;
		next_cycle();
		load_valid = 1'b0;
		waited = 0;
		while (ld_results == results_mark) begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_stall($sformatf("load with tag %0d gave no result", tag));
			end
		end
		check_value(word_t'(seen_tag), word_t'(tag), "load result tag");
		check_value(seen_data, expected, $sformatf("load data at address %h", addr));
		// result and credit come in the same cycle
		check_value(word_t'(ld_returned), word_t'(ld_spent), "ld_credit pulses per load");
	endtask

	initial begin
		int fd;
		int code;
		cmd_t cmd;
		logic [8*128-1:0] line;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		seed = 51;
		reset = 1'b0;
		stq_alloc = 1'b0;
		alloc_tag = '0;
		alloc_data = '0;
		alloc_data_valid = 1'b0;
		agu_valid = 1'b0;
		agu_tag = '0;
		agu_addr = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		commit_valid = 1'b0;
		commit_tag = '0;
		load_valid = 1'b0;
		load_tag = '0;
		load_addr = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b1;
		next_cycle();

		fd = $fopen("test/lsu_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file test/lsu_golden.txt");
			$display("Simulation FAILED");
			$fatal(1, "no stimulus");
		end
		code = $fscanf(fd, "%s", cmd);
		while (code == 1) begin
			if (cmd == cmd_t'("#")) begin
				code = $fgets(line, fd);
			end else if (cmd == cmd_t'("alloc")) begin
				code = $fscanf(fd, "%d %d %h", f1, f2, f3);
				alloc_store(f1[`LSU_TAG_W-1:0], f2[0], f3);
			end else if (cmd == cmd_t'("agu")) begin
				code = $fscanf(fd, "%d %h", f1, f2);
				ev_kind.push_back(EV_AGU);
				ev_tag.push_back(f1[`LSU_TAG_W-1:0]);
				ev_val.push_back(f2);
			end else if (cmd == cmd_t'("cdb")) begin
				code = $fscanf(fd, "%d %h", f1, f2);
				ev_kind.push_back(EV_CDB);
				ev_tag.push_back(f1[`LSU_TAG_W-1:0]);
				ev_val.push_back(f2);
			end else if (cmd == cmd_t'("commit")) begin
				code = $fscanf(fd, "%d", f1);
				ev_kind.push_back(EV_COMMIT);
				ev_tag.push_back(f1[`LSU_TAG_W-1:0]);
				ev_val.push_back('0);
			end else if (cmd == cmd_t'("drain")) begin
				drain_stores();
			end else if (cmd == cmd_t'("load")) begin
				code = $fscanf(fd, "%d %h %h", f1, f2, f3);
				issue_load(f1[`LSU_TAG_W-1:0], f2, f3);
			end else begin
				$display("unknown command in the golden file");
				$display("Simulation FAILED");
				$fatal(1, "bad stimulus");
			end
			code = $fscanf(fd, "%s", cmd);
		end
		$fclose(fd);
		repeat (2) next_cycle();

		if (fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== logic/lsu_top.sv ====
// load/store unit top
`include "lsu_cfg.svh"

module lsu_top (
	input logic clk,
	input logic reset,

	input logic stq_alloc,
	input logic [`LSU_TAG_W-1:0] alloc_tag,
	input logic [`LSU_XLEN-1:0] alloc_data,
	input logic alloc_data_valid,

	input logic agu_valid,
	input logic [`LSU_TAG_W-1:0] agu_tag,
	input logic [`LSU_XLEN-1:0] agu_addr,

	input logic cdb_valid,
	input logic [`LSU_TAG_W-1:0] cdb_tag,
	input logic [`LSU_XLEN-1:0] cdb_data,

	input logic commit_valid,
	input logic [`LSU_TAG_W-1:0] commit_tag,

	input logic load_valid,
	input logic [`LSU_TAG_W-1:0] load_tag,
	input logic [`LSU_XLEN-1:0] load_addr,

	output logic sq_credit,
	output logic ld_credit,
	output logic load_result_valid,
	output logic [`LSU_TAG_W-1:0] load_result_tag,
	output logic [`LSU_XLEN-1:0] load_result_data
);

	// store queue to arbiter
	logic st_req;
	logic st_grant;
	logic [`LSU_XLEN-1:0] st_addr;
	logic [`LSU_XLEN-1:0] st_data;

	// load unit to arbiter
	logic ld_req;
	logic ld_grant;
	logic [`LSU_XLEN-1:0] ld_addr;
	logic ld_rdata_valid;
	logic [`LSU_XLEN-1:0] ld_rdata;

	// arbiter to memory
	lsu_pkg::mem_op_t mem_op;
	logic [`LSU_XLEN-1:0] mem_addr;
	logic [`LSU_XLEN-1:0] mem_wdata;
	logic [`LSU_XLEN-1:0] mem_rdata;

	store_queue stq0 (
		.clk(clk), .reset(reset),
		.stq_alloc(stq_alloc), .alloc_tag(alloc_tag),
		.alloc_data(alloc_data), .alloc_data_valid(alloc_data_valid),
		.agu_valid(agu_valid), .agu_tag(agu_tag), .agu_addr(agu_addr),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.commit_valid(commit_valid), .commit_tag(commit_tag),
		.st_grant(st_grant), .st_req(st_req),
		.st_addr(st_addr), .st_data(st_data), .sq_credit(sq_credit)
	);

	load_unit ldu0 (
		.clk(clk), .reset(reset),
		.load_valid(load_valid), .load_tag(load_tag), .load_addr(load_addr),
		.ld_grant(ld_grant), .ld_rdata_valid(ld_rdata_valid), .ld_rdata(ld_rdata),
		.ld_req(ld_req), .ld_addr(ld_addr), .ld_credit(ld_credit),
		.load_result_valid(load_result_valid), .load_result_tag(load_result_tag),
		.load_result_data(load_result_data)
	);

	mem_arbiter arb0 (
		.clk(clk), .reset(reset),
		.st_req(st_req), .st_addr(st_addr), .st_data(st_data),
		.ld_req(ld_req), .ld_addr(ld_addr),
		.mem_rdata(mem_rdata),
		.st_grant(st_grant), .ld_grant(ld_grant),
		.mem_op(mem_op), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.ld_rdata_valid(ld_rdata_valid), .ld_rdata(ld_rdata)
	);

	data_mem mem0 (
		.clk(clk),
		.mem_op(mem_op),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

endmodule

// ==== logic/data_mem.sv ====
// data memory
`include "lsu_cfg.svh"

module data_mem (
	input logic clk,
	input lsu_pkg::mem_op_t mem_op,
	input logic [`LSU_XLEN-1:0] mem_addr,
	input logic [`LSU_XLEN-1:0] mem_wdata,
	output logic [`LSU_XLEN-1:0] mem_rdata
);

	localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

	logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];
	logic [IDX_W-1:0] word_idx;

	// word addressed, drop the byte offset
	assign word_idx = mem_addr[IDX_W+1:2];

	always_ff @(posedge clk) begin
		if (mem_op == lsu_pkg::op_write) begin
			mem[word_idx] <= mem_wdata;
		end
		// registered read, one cycle latency
		if (mem_op == lsu_pkg::op_read) begin
			mem_rdata <= mem[word_idx];
		end
	end

endmodule

// ==== logic/mem_arbiter.sv ====
// memory port arbiter
`include "lsu_cfg.svh"

module mem_arbiter (
	input logic clk,
	input logic reset,

	// store write-out
	input logic st_req,
	input logic [`LSU_XLEN-1:0] st_addr,
	input logic [`LSU_XLEN-1:0] st_data,

	// load read
	input logic ld_req,
	input logic [`LSU_XLEN-1:0] ld_addr,

	input logic [`LSU_XLEN-1:0] mem_rdata,

	output logic st_grant,
	output logic ld_grant,

	// memory port
	output lsu_pkg::mem_op_t mem_op,
	output logic [`LSU_XLEN-1:0] mem_addr,
	output logic [`LSU_XLEN-1:0] mem_wdata,

	// read return to the load unit
	output logic ld_rdata_valid,
	output logic [`LSU_XLEN-1:0] ld_rdata
);

	lsu_pkg::grant_t last_owner;

	// on contention the side not served last goes first
	assign st_grant = st_req && (!ld_req || last_owner == lsu_pkg::own_load);
	assign ld_grant = ld_req && !st_grant;

	always_comb begin
		mem_op = lsu_pkg::op_none;
		if (st_grant) begin
			mem_op = lsu_pkg::op_write;
		end else if (ld_grant) begin
			mem_op = lsu_pkg::op_read;
		end
	end

	assign mem_addr = st_grant ? st_addr : ld_addr;
	// write data only matters on a write
	assign mem_wdata = st_data;

	always_ff @(posedge clk) begin
		if (!reset) begin
			last_owner <= lsu_pkg::own_load;
			ld_rdata_valid <= 1'b0;
		end else begin
			// memory read data shows up one cycle after the grant
			ld_rdata_valid <= ld_grant;
			if (st_grant) begin
				last_owner <= lsu_pkg::own_store;
			end else if (ld_grant) begin
				last_owner <= lsu_pkg::own_load;
			end
		end
	end

	// only the load unit reads, qualified by ld_rdata_valid
	assign ld_rdata = mem_rdata;

endmodule

// ==== logic/load_unit.sv ====
// single entry load unit
`include "lsu_cfg.svh"

module load_unit (
	input logic clk,
	input logic reset,

	// load issue
	input logic load_valid,
	input logic [`LSU_TAG_W-1:0] load_tag,
	input logic [`LSU_XLEN-1:0] load_addr,

	// memory port side
	input logic ld_grant,
	input logic ld_rdata_valid,
	input logic [`LSU_XLEN-1:0] ld_rdata,
	output logic ld_req,
	output logic [`LSU_XLEN-1:0] ld_addr,
	output logic ld_credit,

	// result broadcast
	output logic load_result_valid,
	output logic [`LSU_TAG_W-1:0] load_result_tag,
	output logic [`LSU_XLEN-1:0] load_result_data
);

	lsu_pkg::load_state_t state;

	// the load being worked on
	logic [`LSU_TAG_W-1:0] held_tag;
	logic [`LSU_XLEN-1:0] held_addr;

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= lsu_pkg::ld_idle;
			load_result_valid <= 1'b0;
			ld_credit <= 1'b0;
		end else begin
			// both are single cycle pulses
			load_result_valid <= 1'b0;
			ld_credit <= 1'b0;
			case (state)
				lsu_pkg::ld_idle: begin
					if (load_valid) begin
						state <= lsu_pkg::ld_request;
					end
				end
				lsu_pkg::ld_request: begin
					if (ld_grant) begin
						state <= lsu_pkg::ld_wait_data;
					end
				end
				lsu_pkg::ld_wait_data: begin
					// result and credit go out together
					if (ld_rdata_valid) begin
						state <= lsu_pkg::ld_idle;
						load_result_valid <= 1'b1;
						ld_credit <= 1'b1;
					end
				end
				default: state <= lsu_pkg::ld_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == lsu_pkg::ld_idle && load_valid) begin
			held_tag <= load_tag;
			held_addr <= load_addr;
		end
		if (state == lsu_pkg::ld_wait_data && ld_rdata_valid) begin
			load_result_data <= ld_rdata;
		end
	end

	// keep asking until the arbiter picks us
	assign ld_req = (state == lsu_pkg::ld_request);
	assign ld_addr = held_addr;

	// tag stays put until the next load, which needs the credit first
	assign load_result_tag = held_tag;

endmodule

// ==== logic/store_queue.sv ====
// store queue
`include "lsu_cfg.svh"

module store_queue (
	input logic clk,
	input logic reset,

	// allocation from dispatch, data may already be known
	input logic stq_alloc,
	input logic [`LSU_TAG_W-1:0] alloc_tag,
	input logic [`LSU_XLEN-1:0] alloc_data,
	input logic alloc_data_valid,

	// address from the agu
	input logic agu_valid,
	input logic [`LSU_TAG_W-1:0] agu_tag,
	input logic [`LSU_XLEN-1:0] agu_addr,

	// late store data off the cdb
	input logic cdb_valid,
	input logic [`LSU_TAG_W-1:0] cdb_tag,
	input logic [`LSU_XLEN-1:0] cdb_data,

	// commit from the rob
	input logic commit_valid,
	input logic [`LSU_TAG_W-1:0] commit_tag,

	// write-out to the arbiter
	input logic st_grant,
	output logic st_req,
	output logic [`LSU_XLEN-1:0] st_addr,
	output logic [`LSU_XLEN-1:0] st_data,
	output logic sq_credit
);

	localparam int PTR_W = $clog2(`LSU_STQ_SIZE);

	// entry status bits
	logic [`LSU_STQ_SIZE-1:0] ent_valid;
	logic [`LSU_STQ_SIZE-1:0] ent_addr_valid;
	logic [`LSU_STQ_SIZE-1:0] ent_data_valid;
	logic [`LSU_STQ_SIZE-1:0] ent_committed;

	// entry payload
	logic [`LSU_TAG_W-1:0] ent_tag [`LSU_STQ_SIZE];
	logic [`LSU_XLEN-1:0] ent_addr [`LSU_STQ_SIZE];
	logic [`LSU_XLEN-1:0] ent_data [`LSU_STQ_SIZE];

	// head is the oldest store, tail the next free slot
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;

	// per-entry tag matches for this cycle
	logic [`LSU_STQ_SIZE-1:0] agu_hit;
	logic [`LSU_STQ_SIZE-1:0] cdb_hit;
	logic [`LSU_STQ_SIZE-1:0] commit_hit;

	logic retire;

	// only live entries can match, a stale tag in a free slot is ignored
	always_comb begin
		for (int i = 0; i < `LSU_STQ_SIZE; i++) begin
			agu_hit[i] = ent_valid[i] && agu_valid && (ent_tag[i] == agu_tag);
			cdb_hit[i] = ent_valid[i] && cdb_valid && (ent_tag[i] == cdb_tag);
			commit_hit[i] = ent_valid[i] && commit_valid && (ent_tag[i] == commit_tag);
		end
	end

	// head goes out once it has everything and the rob let it go
	assign st_req = ent_valid[head] && ent_addr_valid[head]
			&& ent_data_valid[head] && ent_committed[head];
	assign st_addr = ent_addr[head];
	assign st_data = ent_data[head];

	// write happens on the same edge as the grant
	assign retire = st_req && st_grant;

	always_ff @(posedge clk) begin
		if (!reset) begin
			head <= '0;
			tail <= '0;
			sq_credit <= 1'b0;
			ent_valid <= '0;
			ent_addr_valid <= '0;
			ent_data_valid <= '0;
			ent_committed <= '0;
		end else begin
			// one credit back per retired store
			sq_credit <= retire;

			for (int i = 0; i < `LSU_STQ_SIZE; i++) begin
				if (agu_hit[i]) begin
					ent_addr_valid[i] <= 1'b1;
				end
				if (cdb_hit[i]) begin
					ent_data_valid[i] <= 1'b1;
				end
				if (commit_hit[i]) begin
					ent_committed[i] <= 1'b1;
				end
			end

			// new store at the tail
			// dispatch holds a credit so the slot is always free here
			if (stq_alloc) begin
				ent_valid[tail] <= 1'b1;
				ent_addr_valid[tail] <= 1'b0;
				ent_data_valid[tail] <= alloc_data_valid;
				ent_committed[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end

			// dropping valid is enough, the other bits are rewritten on alloc
			if (retire) begin
				ent_valid[head] <= 1'b0;
				head <= head + 1'b1;
			end
		end
	end

	// payload capture
	always_ff @(posedge clk) begin
		for (int i = 0; i < `LSU_STQ_SIZE; i++) begin
			if (agu_hit[i]) begin
				ent_addr[i] <= agu_addr;
			end
			if (cdb_hit[i]) begin
				ent_data[i] <= cdb_data;
			end
		end
		// alloc data lands even when not valid yet, the cdb overwrites it later
		if (stq_alloc) begin
			ent_tag[tail] <= alloc_tag;
			ent_data[tail] <= alloc_data;
		end
	end

endmodule

// ==== logic/lsu_pkg.sv ====
// load/store shared types
package lsu_pkg;

	// operation presented to the data memory port
	typedef enum logic [1:0] {
		op_none,
		op_read,
		op_write
	} mem_op_t;

	// owner of the most recent memory grant
	// used for round robin between the two requesters
	typedef enum logic {
		own_store,
		own_load
	} grant_t;

	// load unit fsm
	typedef enum logic [1:0] {
		ld_idle,
		ld_request,
		ld_wait_data
	} load_state_t;

endpackage

// ==== logic/lsu_cfg.svh ====
// load/store slice sizing
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data and address width
`define LSU_XLEN 32

// rob tag width
`define LSU_TAG_W 5

// store queue entries, power of two so the pointers wrap on their own
// this is also the number of store credits dispatch starts with
`define LSU_STQ_SIZE 8

// data memory depth in words
// word index is taken from the address bits above the byte offset
`define LSU_MEM_WORDS 64

`endif
